//--- axi_read_defs.svh
// Fixed single configuration; MST_ID_W must equal MID_ID_W plus clog2(NUM_PORTS) and is not derived
`ifndef AXI_READ_DEFS_SVH
`define AXI_READ_DEFS_SVH

// Address and data widths are shared by every port of the subsystem
`define AXI_ADDR_W 8
`define AXI_DATA_W 32

// Upstream requestors use wide IDs
`define SLV_ID_W 4

// Remapped ID width, so each requestor gets 2**MID_ID_W slots
// This is also the number of distinct upstream IDs that may be open at once
`define MID_ID_W 2

// Downstream ID carries the requestor index above the slot index
`define MST_ID_W 3

// Number of requestors sharing the downstream read port
`define NUM_PORTS 2

// Upper limit of open reads that may share one upstream ID
// A further read on that ID waits until one of them completes
`define TXNS_PER_ID 3

`endif

//--- source/axi_chan_pkg.sv
// Read channels only, single beat, without user, resp or last fields
`include "axi_read_defs.svh"
`default_nettype none

package axi_chan_pkg;

  typedef logic [`AXI_ADDR_W-1:0] addr_t;
  typedef logic [`AXI_DATA_W-1:0] data_t;

  // One ID type for each point along the read path
  typedef logic [`SLV_ID_W-1:0] slv_id_t;
  typedef logic [`MID_ID_W-1:0] mid_id_t;
  typedef logic [`MST_ID_W-1:0] mst_id_t;

  // Upstream channels as seen by each requestor
  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
  } slv_ar_t;

  typedef struct packed {
    slv_id_t id;
    data_t   data;
  } slv_r_t;

  // Between remapper and arbiter the ID is a slot index
  typedef struct packed {
    mid_id_t id;
    addr_t   addr;
  } mid_ar_t;

  typedef struct packed {
    mid_id_t id;
    data_t   data;
  } mid_r_t;

  // Downstream channels, requestor index in the upper ID bits
  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
  } mst_ar_t;

  typedef struct packed {
    mst_id_t id;
    data_t   data;
  } mst_r_t;

endpackage

`default_nettype wire

//--- source/id_remap_pkg.sv
// Slot table types for one remapper; the counter is sized to hold TXNS_PER_ID exactly
`include "axi_read_defs.svh"
`default_nettype none

package id_remap_pkg;

  // Every narrow ID value is one table slot
  localparam int unsigned NUM_SLOTS = 2 ** `MID_ID_W;

  typedef logic [`MID_ID_W-1:0] slot_idx_t;

  // Open reads on one slot, zero up to TXNS_PER_ID
  typedef logic [$clog2(`TXNS_PER_ID + 1)-1:0] txn_cnt_t;

  // A slot is valid exactly while its count is nonzero
  typedef struct packed {
    logic                  valid;
    logic [`SLV_ID_W-1:0]  id;
    txn_cnt_t              cnt;
  } remap_entry_t;

endpackage

`default_nettype wire

//--- source/axi_read_if.sv
// Read-only AXI link with valid/ready on AR and R; payload types are set per instance
`default_nettype none

interface axi_read_if #(
  // Address channel payload
  parameter type ar_t = logic,
  // Read data channel payload
  parameter type r_t  = logic
);

  logic ar_valid;
  logic ar_ready;
  ar_t  ar;

  logic r_valid;
  logic r_ready;
  r_t   r;

  // Side that issues reads and takes responses
  modport master (
    output ar_valid,
    output ar,
    input  ar_ready,
    input  r_valid,
    input  r,
    output r_ready
  );

  // Side that accepts reads and returns responses
  modport slave (
    input  ar_valid,
    input  ar,
    output ar_ready,
    output r_valid,
    output r,
    input  r_ready
  );

endinterface

`default_nettype wire

//--- source/axi_id_remap.sv
// Packs at most 2**MID_ID_W open upstream IDs into slots; R beats must only use slots issued here
`include "axi_read_defs.svh"
`default_nettype none

module axi_id_remap (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  slv_ar_valid_i,
  input  axi_chan_pkg::slv_ar_t slv_ar_i,
  output logic                  slv_ar_ready_o,
  output logic                  slv_r_valid_o,
  output axi_chan_pkg::slv_r_t  slv_r_o,
  input  logic                  slv_r_ready_i,
  axi_read_if.master            mst
);

  import axi_chan_pkg::*;
  import id_remap_pkg::*;

  remap_entry_t          table_q [NUM_SLOTS];
  txn_cnt_t              cnt_next [NUM_SLOTS];
  logic [NUM_SLOTS-1:0]  inc;
  logic [NUM_SLOTS-1:0]  dec;

  logic       hit;
  slot_idx_t  hit_idx;
  logic       free_found;
  slot_idx_t  free_idx;

  logic       hold_q;
  slot_idx_t  hold_idx_q;

  slot_idx_t  ar_idx;
  logic       ar_stall;
  logic       ar_hs;
  slot_idx_t  r_idx;
  logic       r_hs;
  mid_ar_t    mid_ar;

  // Look for a slot already holding this ID and for the lowest free slot
  // Scanning downwards lets the lowest index win
  always_comb begin
    hit        = 1'b0;
    hit_idx    = '0;
    free_found = 1'b0;
    free_idx   = '0;
    for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
      if (table_q[s].valid && (table_q[s].id == slv_ar_i.id)) begin
        hit     = 1'b1;
        hit_idx = slot_idx_t'(s);
      end
      if (!table_q[s].valid) begin
        free_found = 1'b1;
        free_idx   = slot_idx_t'(s);
      end
    end
  end

  // A request that already went out but was not accepted keeps its slot
  // Otherwise a slot freed meanwhile could change the ID under a raised valid
  always_comb begin
    if (hold_q) begin
      ar_idx   = hold_idx_q;
      ar_stall = 1'b0;
    end else if (hit) begin
      ar_idx   = hit_idx;
      // Same ID reuses its slot up to the per-ID limit
      ar_stall = (table_q[hit_idx].cnt == txn_cnt_t'(`TXNS_PER_ID));
    end else begin
      ar_idx   = free_idx;
      ar_stall = !free_found;
    end
  end

  assign mst.ar_valid   = slv_ar_valid_i && !ar_stall;
  assign slv_ar_ready_o = mst.ar_ready && !ar_stall;
  assign ar_hs          = mst.ar_valid && mst.ar_ready;

  // Address passes through, the slot index becomes the ID
  always_comb begin
    mid_ar.id   = ar_idx;
    mid_ar.addr = slv_ar_i.addr;
  end
  assign mst.ar = mid_ar;

  // Response side restores the original ID from the slot
  assign r_idx         = mst.r.id;
  assign slv_r_valid_o = mst.r_valid;
  assign mst.r_ready   = slv_r_ready_i;
  assign r_hs          = mst.r_valid && slv_r_ready_i;

  always_comb begin
    slv_r_o.id   = table_q[r_idx].id;
    slv_r_o.data = mst.r.data;
  end

  // Per slot count update, an AR and an R on one slot in one cycle cancel out
  always_comb begin
    for (int s = 0; s < NUM_SLOTS; s++) begin
      inc[s]      = ar_hs && (ar_idx == slot_idx_t'(s));
      dec[s]      = r_hs && (r_idx == slot_idx_t'(s));
      cnt_next[s] = table_q[s].cnt + txn_cnt_t'(inc[s]) - txn_cnt_t'(dec[s]);
    end
  end

  always_ff @(posedge clk_i) begin
    hold_idx_q <= ar_idx;
    if (reset_i) begin
      hold_q <= 1'b0;
    end else begin
      hold_q <= mst.ar_valid && !mst.ar_ready;
    end
  end

  // The slot becomes free in the cycle after its last response
  always_ff @(posedge clk_i) begin
    for (int s = 0; s < NUM_SLOTS; s++) begin
      if (inc[s]) begin
        table_q[s].id <= slv_ar_i.id;
      end
      if (reset_i) begin
        table_q[s].valid <= 1'b0;
        table_q[s].cnt   <= '0;
      end else begin
        table_q[s].valid <= (cnt_next[s] != '0);
        table_q[s].cnt   <= cnt_next[s];
      end
    end
  end

  // Downstream may only answer slots that this remapper has handed out
  a_r_slot_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    mst.r_valid |-> table_q[r_idx].valid);

  // A slot at the per-ID limit takes no further read unless one completes in the same cycle
  for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_cnt_chk
    a_cnt_max: assert property (@(posedge clk_i) disable iff (reset_i)
      (table_q[s].cnt == txn_cnt_t'(`TXNS_PER_ID)) |-> !(inc[s] && !dec[s]));
  end

endmodule

`default_nettype wire

//--- source/axi_read_arbiter.sv
// Round-robin AR arbiter; assumes NUM_PORTS fits the ID bits above MID_ID_W in the downstream ID
`include "axi_read_defs.svh"
`default_nettype none

module axi_read_arbiter (
  input  logic                  clk_i,
  input  logic                  reset_i,
  axi_read_if.slave             slv [`NUM_PORTS],
  output logic                  mst_ar_valid_o,
  output axi_chan_pkg::mst_ar_t mst_ar_o,
  input  logic                  mst_ar_ready_i,
  input  logic                  mst_r_valid_i,
  input  axi_chan_pkg::mst_r_t  mst_r_i,
  output logic                  mst_r_ready_o
);

  import axi_chan_pkg::*;

  localparam int NP    = `NUM_PORTS;
  localparam int IDX_W = `MST_ID_W - `MID_ID_W;

  typedef logic [IDX_W-1:0] idx_t;

  logic [NP-1:0] req;
  mid_ar_t       ar_in [NP];
  logic [NP-1:0] r_ready_in;
  logic [NP-1:0] gnt;

  logic    rr_found;
  idx_t    rr_idx;
  logic    sel_valid;
  idx_t    sel_idx;
  logic    ar_hs;

  logic    lock_q;
  idx_t    lock_idx_q;
  idx_t    ptr_q;

  idx_t    r_idx;
  mid_r_t  r_out;

  // Response routing uses the requestor index in the top ID bits
  assign r_idx      = mst_r_i.id[`MST_ID_W-1 -: IDX_W];
  assign r_out.id   = mst_r_i.id[`MID_ID_W-1:0];
  assign r_out.data = mst_r_i.data;

  // Interface arrays need constant indices, so each port is copied out here
  for (genvar p = 0; p < NP; p++) begin : g_port
    assign req[p]        = slv[p].ar_valid;
    assign ar_in[p]      = slv[p].ar;
    assign slv[p].ar_ready = gnt[p] && mst_ar_ready_i;
    assign slv[p].r_valid  = mst_r_valid_i && (r_idx == idx_t'(p));
    assign slv[p].r        = r_out;
    assign r_ready_in[p]   = slv[p].r_ready;
  end

  // Only the addressed requestor may accept the beat
  assign mst_r_ready_o = r_ready_in[r_idx];

  // Search starts at the pointer and wraps around
  always_comb begin
    int cand;
    rr_found = 1'b0;
    rr_idx   = ptr_q;
    for (int k = 0; k < NP; k++) begin
      cand = (int'(ptr_q) + k) % NP;
      if (!rr_found && req[cand]) begin
        rr_found = 1'b1;
        rr_idx   = idx_t'(cand);
      end
    end
  end

  // A request already shown downstream keeps the grant until accepted
  always_comb begin
    if (lock_q) begin
      sel_valid = 1'b1;
      sel_idx   = lock_idx_q;
    end else begin
      sel_valid = rr_found;
      sel_idx   = rr_idx;
    end
    gnt = '0;
    if (sel_valid) begin
      gnt[sel_idx] = 1'b1;
    end
  end

  assign mst_ar_valid_o = sel_valid && req[sel_idx];
  assign ar_hs          = mst_ar_valid_o && mst_ar_ready_i;

  // Winner index goes in front of the slot ID
  always_comb begin
    mst_ar_o.id   = {sel_idx, ar_in[sel_idx].id};
    mst_ar_o.addr = ar_in[sel_idx].addr;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
      ptr_q      <= '0;
    end else begin
      lock_q     <= mst_ar_valid_o && !mst_ar_ready_i;
      lock_idx_q <= sel_idx;
      // Next search begins just past the requestor that was served
      if (ar_hs) begin
        ptr_q <= idx_t'((int'(sel_idx) + 1) % NP);
      end
    end
  end

  // A requestor passed over at a handshake is granted in the following cycle when there are two
  for (genvar p = 0; p < NP; p++) begin : g_fair_chk
    a_rr_fair: assert property (@(posedge clk_i) disable iff (reset_i)
      ar_hs && req[p] && !gnt[p] |=> gnt[p]);
  end

  // Holds only if the remappers keep their slot while the grant is locked
  a_ar_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_ar_valid_o && !mst_ar_ready_i |=> mst_ar_valid_o && $stable(mst_ar_o));

endmodule

`default_nettype wire

//--- source/axi_read_subsystem.sv
// Two requestors onto one read port; AR and R are combinational end to end, single-beat reads only
`include "axi_read_defs.svh"
`default_nettype none

module axi_read_subsystem (
  input  logic                   clk_i,
  input  logic                   reset_i,

  // Upstream requestors, indexed by requestor
  input  logic [`NUM_PORTS-1:0]  ar_valid_i,
  output logic [`NUM_PORTS-1:0]  ar_ready_o,
  input  logic [`SLV_ID_W-1:0]   ar_id_i   [`NUM_PORTS],
  input  logic [`AXI_ADDR_W-1:0] ar_addr_i [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0]  r_valid_o,
  input  logic [`NUM_PORTS-1:0]  r_ready_i,
  output logic [`SLV_ID_W-1:0]   r_id_o    [`NUM_PORTS],
  output logic [`AXI_DATA_W-1:0] r_data_o  [`NUM_PORTS],

  // Shared downstream read port
  output logic                   m_ar_valid_o,
  input  logic                   m_ar_ready_i,
  output logic [`MST_ID_W-1:0]   m_ar_id_o,
  output logic [`AXI_ADDR_W-1:0] m_ar_addr_o,
  input  logic                   m_r_valid_i,
  output logic                   m_r_ready_o,
  input  logic [`MST_ID_W-1:0]   m_r_id_i,
  input  logic [`AXI_DATA_W-1:0] m_r_data_i
);

  import axi_chan_pkg::*;

  // Links between each remapper and the arbiter carry slot IDs
  axi_read_if #(
    .ar_t (mid_ar_t),
    .r_t  (mid_r_t)
  ) mid_if [`NUM_PORTS] ();

  mst_ar_t m_ar;
  mst_r_t  m_r;

  for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_req
    slv_ar_t up_ar;
    slv_r_t  up_r;

    assign up_ar.id    = ar_id_i[p];
    assign up_ar.addr  = ar_addr_i[p];
    assign r_id_o[p]   = up_r.id;
    assign r_data_o[p] = up_r.data;

    axi_id_remap axi_id_remap_inst (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .slv_ar_valid_i (ar_valid_i[p]),
      .slv_ar_i       (up_ar),
      .slv_ar_ready_o (ar_ready_o[p]),
      .slv_r_valid_o  (r_valid_o[p]),
      .slv_r_o        (up_r),
      .slv_r_ready_i  (r_ready_i[p]),
      .mst            (mid_if[p])
    );
  end

  axi_read_arbiter axi_read_arbiter_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .slv            (mid_if),
    .mst_ar_valid_o (m_ar_valid_o),
    .mst_ar_o       (m_ar),
    .mst_ar_ready_i (m_ar_ready_i),
    .mst_r_valid_i  (m_r_valid_i),
    .mst_r_i        (m_r),
    .mst_r_ready_o  (m_r_ready_o)
  );

  // Downstream structs unpacked onto the flat port
  assign m_ar_id_o   = m_ar.id;
  assign m_ar_addr_o = m_ar.addr;
  assign m_r.id      = m_r_id_i;
  assign m_r.data    = m_r_data_i;

endmodule

`default_nettype wire

//--- verification/tb_axi_read_subsystem.sv
// Random and directed reads with the testbench as downstream slave; IDs and counts follow axi_read_defs.svh
`include "axi_read_defs.svh"
`default_nettype none

module tb_axi_read_subsystem;

  import axi_chan_pkg::*;

  localparam int NP       = `NUM_PORTS;
  localparam int IDX_W    = `MST_ID_W - `MID_ID_W;
  localparam int NUM_IDS  = 1 << `SLV_ID_W;
  localparam int NUM_MIDS = 1 << `MST_ID_W;
  localparam int NUM_RND  = 200;
  localparam data_t RESP_PAT = 32'h5a3c_96e1;

  typedef logic [IDX_W-1:0] idx_t;

  logic          clk = 1'b0;
  logic          reset;
  logic [NP-1:0] ar_valid;
  logic [NP-1:0] ar_ready;
  slv_id_t       ar_id [NP];
  addr_t         ar_addr [NP];
  logic [NP-1:0] r_valid;
  logic [NP-1:0] r_ready;
  slv_id_t       r_id [NP];
  data_t         r_data [NP];
  logic          m_ar_valid;
  logic          m_ar_ready;
  mst_id_t       m_ar_id;
  addr_t         m_ar_addr;
  logic          m_r_valid;
  logic          m_r_ready;
  mst_id_t       m_r_id;
  data_t         m_r_data;

  // Requests waiting to be raised, the model of open reads, and the slave's per-ID queues
  slv_id_t       req_id_q [NP][$];
  addr_t         req_addr_q [NP][$];
  addr_t         exp_q [NP][NUM_IDS][$];
  addr_t         slv_q [NUM_MIDS][$];
  slv_id_t       up_id_q [NUM_MIDS][$];

  logic [31:0]   lfsr_state = 32'h7f43_1071;
  logic [NP-1:0] ar_busy;
  logic          r_busy;
  int            ar_cnt [NP];
  logic          rand_mode;
  logic          resp_en;
  logic          alt_chk;
  logic          have_last;
  idx_t          last_gnt;

  always #50 clk = ~clk;

  axi_read_subsystem axi_read_subsystem_inst (
    .clk_i        (clk),
    .reset_i      (reset),
    .ar_valid_i   (ar_valid),
    .ar_ready_o   (ar_ready),
    .ar_id_i      (ar_id),
    .ar_addr_i    (ar_addr),
    .r_valid_o    (r_valid),
    .r_ready_i    (r_ready),
    .r_id_o       (r_id),
    .r_data_o     (r_data),
    .m_ar_valid_o (m_ar_valid),
    .m_ar_ready_i (m_ar_ready),
    .m_ar_id_o    (m_ar_id),
    .m_ar_addr_o  (m_ar_addr),
    .m_r_valid_i  (m_r_valid),
    .m_r_ready_o  (m_r_ready),
    .m_r_id_i     (m_r_id),
    .m_r_data_i   (m_r_data)
  );

  // Galois LFSR, one step per random bit
  function automatic logic rand_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 32'hd000_0001;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], rand_bit()};
    end
    return v;
  endfunction

  // The slave answers every read with its address folded into a fixed pattern
  function automatic data_t resp_data(input addr_t a);
    return data_t'(a) ^ RESP_PAT;
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int p = 0; p < NP; p++) begin
      for (int i = 0; i < NUM_IDS; i++) begin
        n += exp_q[p][i].size();
      end
    end
    return n;
  endfunction

  function automatic logic busy();
    logic b;
    b = r_busy || (ar_busy != '0) || (outstanding() != 0);
    for (int p = 0; p < NP; p++) begin
      b = b || (req_id_q[p].size() != 0);
    end
    return b;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic queue_read(input int p, input slv_id_t id, input addr_t addr);
    req_id_q[p].push_back(id);
    req_addr_q[p].push_back(addr);
  endtask

  // New inputs go out on the rising edge, a raised valid is held until its handshake
  task automatic drive_inputs();
    int start;
    int sel;
    for (int p = 0; p < NP; p++) begin
      if (!ar_busy[p] && req_id_q[p].size() > 0 && (!rand_mode || rand_bit())) begin
        ar_busy[p] = 1'b1;
        ar_id[p]   <= req_id_q[p].pop_front();
        ar_addr[p] <= req_addr_q[p].pop_front();
      end
      ar_valid[p] <= ar_busy[p];
      r_ready[p]  <= rand_mode ? rand_bit() : 1'b1;
    end
    m_ar_ready <= rand_mode ? rand_bit() : 1'b1;
    // Start the search at a random downstream ID, so order holds only within one ID
    if (!r_busy && resp_en && (!rand_mode || rand_bit())) begin
      start = int'(rand_bits(`MST_ID_W));
      for (int k = 0; k < NUM_MIDS; k++) begin
        sel = (start + k) % NUM_MIDS;
        if (!r_busy && slv_q[sel].size() > 0) begin
          r_busy = 1'b1;
          m_r_id   <= mst_id_t'(sel);
          m_r_data <= resp_data(slv_q[sel].pop_front());
        end
      end
    end
    m_r_valid <= r_busy;
  endtask

  // Mid-cycle sampling, each handshake seen here completes on the next rising edge
  task automatic observe();
    int    hs_n;
    idx_t  ar_port;
    idx_t  r_port;
    addr_t a;
    hs_n    = 0;
    ar_port = m_ar_id[`MST_ID_W-1 -: IDX_W];
    r_port  = m_r_id[`MST_ID_W-1 -: IDX_W];
    for (int q = 0; q < NP; q++) begin
      check($sformatf("r_valid_o[%0d]", q), 32'(r_valid[q]),
            32'(m_r_valid && (r_port == idx_t'(q))));
      if (ar_valid[q] && ar_ready[q]) begin
        hs_n++;
        check("m_ar_id_o index", 32'(ar_port), 32'(q));
        check("m_ar_addr_o", 32'(m_ar_addr), 32'(ar_addr[q]));
        exp_q[q][ar_id[q]].push_back(ar_addr[q]);
        ar_busy[q] = 1'b0;
        ar_cnt[q]++;
      end
    end
    check("accepted AR count", 32'(hs_n), 32'(m_ar_valid && m_ar_ready));
    if (m_ar_valid && m_ar_ready) begin
      slv_q[m_ar_id].push_back(m_ar_addr);
      up_id_q[m_ar_id].push_back(ar_id[ar_port]);
      // With both requestors waiting the winner must change every time
      if (alt_chk && have_last) begin
        check("granted requestor", 32'(ar_port), (int'(last_gnt) + 1) % NP);
      end
      have_last = 1'b1;
      last_gnt  = ar_port;
    end
    if (m_r_valid) begin
      check("m_r_ready_o", 32'(m_r_ready), 32'(r_ready[r_port]));
    end
    if (m_r_valid && m_r_ready) begin
      check("r_id_o", 32'(r_id[r_port]), 32'(up_id_q[m_r_id].pop_front()));
      if (exp_q[r_port][r_id[r_port]].size() == 0) begin
        fail_run($sformatf("requestor %0d got a response on ID 0x%0h with no read open",
                           r_port, r_id[r_port]));
      end else begin
        a = exp_q[r_port][r_id[r_port]].pop_front();
        check("r_data_o", r_data[r_port], resp_data(a));
      end
      r_busy = 1'b0;
    end
  endtask

  task automatic step();
    @(posedge clk);
    drive_inputs();
    @(negedge clk);
    observe();
  endtask

  task automatic wait_drain(input string what, input int limit);
    int n;
    n = 0;
    while (busy() && n < limit) begin
      step();
      n++;
    end
    if (busy()) begin
      fail_run($sformatf("Timed out waiting for %s", what));
    end
  endtask

  task automatic wait_ar_count(input int p, input int target, input string what);
    int n;
    n = 0;
    while (ar_cnt[p] < target && n < 200) begin
      step();
      n++;
    end
    if (ar_cnt[p] < target) begin
      fail_run($sformatf("Timed out waiting for %s", what));
    end
  endtask

  // The DUT keeps ar_ready low for each masked requestor and shows nothing downstream
  task automatic hold_stalled(input logic [NP-1:0] mask, input int n);
    for (int i = 0; i < n; i++) begin
      step();
      for (int p = 0; p < NP; p++) begin
        if (mask[p]) begin
          check($sformatf("ar_ready_o[%0d]", p), 32'(ar_ready[p]), 32'd0);
        end
      end
      check("m_ar_valid_o", 32'(m_ar_valid), 32'd0);
    end
  endtask

  initial begin
    int start_cnt1;
    reset      = 1'b1;
    ar_valid   = '0;
    r_ready    = '0;
    m_ar_ready = 1'b0;
    m_r_valid  = 1'b0;
    m_r_id     = '0;
    m_r_data   = '0;
    ar_busy    = '0;
    r_busy     = 1'b0;
    rand_mode  = 1'b0;
    resp_en    = 1'b0;
    alt_chk    = 1'b0;
    have_last  = 1'b0;
    last_gnt   = '0;
    for (int p = 0; p < NP; p++) begin
      ar_id[p]   = '0;
      ar_addr[p] = '0;
      ar_cnt[p]  = 0;
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check("r_valid_o", 32'(r_valid), 32'd0);
    check("m_ar_valid_o", 32'(m_ar_valid), 32'd0);

    // Six upstream IDs, so both remappers run out of slots now and then
    for (int p = 0; p < NP; p++) begin
      for (int i = 0; i < NUM_RND; i++) begin
        queue_read(p, slv_id_t'((int'(rand_bits(3)) % 6) * 3), addr_t'(rand_bits(`AXI_ADDR_W)));
      end
    end
    rand_mode = 1'b1;
    resp_en   = 1'b1;
    wait_drain("the random reads to complete", 50000);
    rand_mode = 1'b0;
    resp_en   = 1'b0;

    // Four distinct IDs fill every slot of requestor 0, the fifth must wait
    for (int i = 0; i < 5; i++) begin
      queue_read(0, slv_id_t'(i + 1), addr_t'(16 * i + 3));
    end
    wait_ar_count(0, ar_cnt[0] + 4, "four distinct IDs to be accepted");
    hold_stalled(2'b01, 8);
    resp_en = 1'b1;
    wait_drain("the fifth distinct ID to complete", 200);
    resp_en = 1'b0;

    // Both requestors on one ID each, grants alternate until the per-ID limit stops them
    for (int i = 0; i < 4; i++) begin
      queue_read(0, 4'h6, addr_t'(8'h80 + i));
      queue_read(1, 4'h6, addr_t'(8'hc0 + i));
    end
    alt_chk   = 1'b1;
    have_last = 1'b0;
    // Requestor 1 is served while requestor 0 is awaited, so its start count is taken first
    start_cnt1 = ar_cnt[1];
    wait_ar_count(0, ar_cnt[0] + `TXNS_PER_ID, "requestor 0 to reach the per-ID limit");
    wait_ar_count(1, start_cnt1 + `TXNS_PER_ID, "requestor 1 to reach the per-ID limit");
    alt_chk = 1'b0;
    hold_stalled(2'b11, 8);
    resp_en = 1'b1;
    wait_drain("the reads beyond the per-ID limit to complete", 200);

    if (busy()) begin
      fail_run("Reads were still open at the end of the run");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
source/axi_chan_pkg.sv
source/id_remap_pkg.sv
source/axi_read_if.sv
source/axi_id_remap.sv
source/axi_read_arbiter.sv
source/axi_read_subsystem.sv
verification/tb_axi_read_subsystem.sv

//--- Makefile
# Verilator build and run of the read subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_read_subsystem
FILELIST  ?= sources.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q -x '>>> PASS' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
